//--- filelist.f
src/ifu_pkg.sv
src/ifu_fetch_ctrl.sv
src/ifu_instr_align.sv
src/ifu_instr_queue.sv
src/ifu_top.sv
verification/tb_ifu_imem.sv
verification/tb_ifu_top.sv

//--- run.sh
#!/bin/sh
# Build and run the fetch unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_ifu_top \
    -f filelist.f --Mdir obj_dir -o tb_ifu_top
status=$?
if [ $status -ne 0 ]; then
    echo "Build failed with status $status"
    exit 1
fi

./obj_dir/tb_ifu_top > sim.log 2>&1
status=$?
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0

//--- src/ifu_fetch_ctrl.sv
`timescale 1ns/1ps
//----------------------------------------------------------------------
// Fetch FSM, address and held-address registers, pending and discard
// counters, memory request gating
//----------------------------------------------------------------------

module ifu_fetch_ctrl
    import ifu_pkg::*;
#(
    parameter int queue_words = 8,
    parameter int txn_cnt_w   = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stop_fetch_i,
    input  logic                 pc_new_req_i,
    input  logic [xlen-1:0]      pc_new_i,
    input  logic                 imem_ack_i,
    input  logic [1:0]           imem_resp_i,
    input  logic [txn_cnt_w-1:0] free_words_i,
    output logic                 imem_req_o,
    output logic [xlen-1:0]      imem_addr_o,
    output logic                 resp_ok_o,
    output logic                 resp_er_o,
    output logic                 flush_o,
    output logic                 fetching_o
);

    localparam logic st_idle  = 1'b0;
    localparam logic st_fetch = 1'b1;

    logic                 fsm_ff;
    logic                 fsm_next;
    logic                 fetch_start;
    logic                 fetch_stop;

    logic                 resp_ok;
    logic                 resp_er;
    logic                 resp_rcvd;
    logic                 handshake;
    logic                 req_waiting;

    logic [xlen-1:0]      addr_ff;
    logic [xlen-1:0]      held_addr_ff;
    logic                 held_ff;

    logic [txn_cnt_w-1:0] pnd_cnt;
    logic [txn_cnt_w-1:0] pnd_cnt_next;
    logic [txn_cnt_w-1:0] discard_cnt;
    logic [txn_cnt_w-1:0] vd_pnd_cnt;
    logic                 discard_req;
    logic                 discard_load;

    //------------------------------------------------------------------
    // Response filter
    //------------------------------------------------------------------

    assign resp_ok     = (imem_resp_i == imem_resp_ok);
    assign resp_er     = (imem_resp_i == imem_resp_er);
    assign resp_rcvd   = resp_ok | resp_er;
    assign discard_req = |discard_cnt;

    // Only responses that belong to the current stream
    assign resp_ok_o = resp_ok & ~discard_req;
    assign resp_er_o = resp_er & ~discard_req;
    assign flush_o   = pc_new_req_i | stop_fetch_i;

    //------------------------------------------------------------------
    // Fetch FSM
    //------------------------------------------------------------------

    assign fetch_start = pc_new_req_i & ~stop_fetch_i;
    // Error stops fetch unless a new PC arrives with it
    assign fetch_stop  = stop_fetch_i | (resp_er_o & ~pc_new_req_i);

    always_comb begin
        fsm_next = fsm_ff;
        case (fsm_ff)
            st_idle:  if (fetch_start) fsm_next = st_fetch;
            st_fetch: if (fetch_stop) fsm_next = st_idle;
            default:  fsm_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fsm_ff <= st_idle;
        end else begin
            fsm_ff <= fsm_next;
        end
    end

    assign fetching_o = (fsm_ff == st_fetch);

    //------------------------------------------------------------------
    // Address registers
    //------------------------------------------------------------------

    assign handshake   = imem_req_o & imem_ack_i;
    // Request out but not yet taken, address must not move
    assign req_waiting = imem_req_o & ~imem_ack_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_ff <= '0;
            held_ff <= 1'b0;
        end else if (pc_new_req_i) begin
            if (req_waiting) begin
                held_ff <= 1'b1;
            end else begin
                addr_ff <= {pc_new_i[xlen-1:2], 2'b00};
                held_ff <= 1'b0;
            end
        end else if (handshake) begin
            // Held PC takes over once the old request is gone
            if (held_ff) begin
                addr_ff <= held_addr_ff;
                held_ff <= 1'b0;
            end else begin
                addr_ff <= addr_ff + xlen'(4);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pc_new_req_i & req_waiting) begin
            held_addr_ff <= {pc_new_i[xlen-1:2], 2'b00};
        end
    end

    //------------------------------------------------------------------
    // Pending and discard counters
    //------------------------------------------------------------------

    assign pnd_cnt_next = pnd_cnt + txn_cnt_w'(handshake) - txn_cnt_w'(resp_rcvd);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pnd_cnt <= '0;
        end else begin
            pnd_cnt <= pnd_cnt_next;
        end
    end

    // Everything in flight is stale after a flush, an error, or
    // while a held PC waits behind the old request
    assign discard_load = flush_o | resp_er_o | held_ff;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            discard_cnt <= '0;
        end else if (discard_load) begin
            discard_cnt <= pnd_cnt_next;
        end else if (resp_rcvd & discard_req) begin
            discard_cnt <= discard_cnt - 1'b1;
        end
    end

    assign vd_pnd_cnt = pnd_cnt - discard_cnt;

    // Request gating
    assign imem_req_o  = fetching_o & ~(&pnd_cnt) & (free_words_i > vd_pnd_cnt);
    assign imem_addr_o = addr_ff;

    a_txn_bound: assert property (@(posedge clk) disable iff (!rst_n)
        (discard_cnt <= pnd_cnt) && (vd_pnd_cnt <= queue_words))
        else $error("fetch ctrl: discard or valid pending count out of range");

    // Waiting request keeps its address, also across a held new PC
    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        req_waiting |=> (!imem_req_o || $stable(imem_addr_o)))
        else $error("fetch ctrl: request address moved before acknowledge");

endmodule

//--- src/ifu_instr_align.sv
`timescale 1ns/1ps
//----------------------------------------------------------------------
// Instruction realignment flags, word type decode, write-size strobes
//----------------------------------------------------------------------

module ifu_instr_align
    import ifu_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            pc_new_req_i,
    input  logic [xlen-1:0] pc_new_i,
    input  fetch_word_u     imem_rdata_i,
    input  logic            resp_ok_i,
    output logic            wr_full_o,
    output logic            wr_hi_o
);

    // Word type, named upper half then lower half
    localparam logic [2:0] it_none          = 3'd0;
    localparam logic [2:0] it_rvi_hi_rvi_lo = 3'd1;
    localparam logic [2:0] it_rvc_rvc       = 3'd2;
    localparam logic [2:0] it_rvi_lo_rvc    = 3'd3;
    localparam logic [2:0] it_rvc_rvi_hi    = 3'd4;
    localparam logic [2:0] it_rvi_lo_rvi_hi = 3'd5;
    // Lower half skipped after a halfword new PC
    localparam logic [2:0] it_rvc_nv        = 3'd6;
    localparam logic [2:0] it_rvi_lo_nv     = 3'd7;

    logic       unaligned_ff;
    logic       hi_rvi_lo_ff;
    logic       hi_rvi_lo_next;
    logic       hi_is_rvi;
    logic       lo_is_rvi;
    logic [2:0] instr_type;

    // Low opcode pair 11 marks a 32-bit instruction
    assign hi_is_rvi = &imem_rdata_i.half.hi[1:0];
    assign lo_is_rvi = &imem_rdata_i.half.lo[1:0];

    always_comb begin
        instr_type = it_none;
        if (resp_ok_i) begin
            if (unaligned_ff) begin
                instr_type = hi_is_rvi ? it_rvi_lo_nv : it_rvc_nv;
            end else if (hi_rvi_lo_ff) begin
                // Lower half finishes the previous word's instruction
                instr_type = hi_is_rvi ? it_rvi_lo_rvi_hi : it_rvc_rvi_hi;
            end else if (lo_is_rvi) begin
                instr_type = it_rvi_hi_rvi_lo;
            end else begin
                instr_type = hi_is_rvi ? it_rvi_lo_rvc : it_rvc_rvc;
            end
        end
    end

    // Word ends with the first half of a 32-bit instruction
    assign hi_rvi_lo_next = (instr_type == it_rvi_lo_nv)
                          | (instr_type == it_rvi_lo_rvi_hi)
                          | (instr_type == it_rvi_lo_rvc);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            unaligned_ff <= 1'b0;
            hi_rvi_lo_ff <= 1'b0;
        end else if (pc_new_req_i) begin
            unaligned_ff <= pc_new_i[1];
            hi_rvi_lo_ff <= 1'b0;
        end else if (resp_ok_i) begin
            unaligned_ff <= 1'b0;
            hi_rvi_lo_ff <= hi_rvi_lo_next;
        end
    end

    // Queue write size
    assign wr_hi_o   = (instr_type == it_rvc_nv) | (instr_type == it_rvi_lo_nv);
    assign wr_full_o = (instr_type != it_none) & ~wr_hi_o;

endmodule

//--- src/ifu_instr_queue.sv
`timescale 1ns/1ps
//----------------------------------------------------------------------
// Halfword instruction queue, pointers, status, decoder output mux
//----------------------------------------------------------------------

module ifu_instr_queue
    import ifu_pkg::*;
#(
    parameter int queue_words = 8,
    parameter int txn_cnt_w   = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush_i,
    input  logic                 wr_full_i,
    input  logic                 wr_hi_i,
    input  logic                 resp_er_i,
    input  fetch_word_u          rdata_i,
    input  logic                 idu_rdy_i,
    output logic [txn_cnt_w-1:0] free_words_o,
    output logic                 idu_vd_o,
    output logic [xlen-1:0]      idu_instr_o,
    output logic                 idu_imem_err_o,
    output logic                 idu_err_rvi_hi_o
);

    localparam int half_n  = 2 * queue_words;
    localparam int adr_w   = $clog2(half_n);
    localparam int ptr_w   = adr_w + 1;
    localparam int cnt_max = (1 << txn_cnt_w) - 1;

    logic [half_w-1:0] q_data [half_n];
    logic              q_err  [half_n];

    logic [ptr_w-1:0]  wptr;
    logic [ptr_w-1:0]  rptr;
    logic [adr_w-1:0]  wr_idx;
    logic [adr_w-1:0]  wr_idx1;
    logic [adr_w-1:0]  head_idx;
    logic [adr_w-1:0]  next_idx;
    logic              wr_en;
    logic              wr_two;
    logic              rd_en;
    logic              rd_one;

    logic [ptr_w-1:0]  ocpd_h;
    logic [ptr_w-1:0]  free_h;
    logic [ptr_w-1:0]  free_w;
    logic              q_empty;
    logic              q_one_hw;

    logic [half_w-1:0] data_head;
    logic [half_w-1:0] data_next;
    logic              err_head;
    logic              err_next;
    logic              head_rvi;

    //------------------------------------------------------------------
    // Write side
    //------------------------------------------------------------------

    // Error words always go in whole
    assign wr_en   = (wr_full_i | wr_hi_i | resp_er_i) & ~flush_i;
    assign wr_two  = wr_full_i | resp_er_i;
    assign wr_idx  = wptr[adr_w-1:0];
    assign wr_idx1 = wr_idx + 1'b1;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (wr_two) begin
                q_data[wr_idx]  <= rdata_i.half.lo;
                q_err[wr_idx]   <= resp_er_i;
                q_data[wr_idx1] <= rdata_i.half.hi;
                q_err[wr_idx1]  <= resp_er_i;
            end else begin
                q_data[wr_idx]  <= rdata_i.half.hi;
                q_err[wr_idx]   <= resp_er_i;
            end
        end
    end

    // Pointers, one wrap bit above the slot index
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wptr <= '0;
            rptr <= '0;
        end else if (flush_i) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (wr_en) begin
                wptr <= wptr + (wr_two ? ptr_w'(2) : ptr_w'(1));
            end
            if (rd_en) begin
                rptr <= rptr + (rd_one ? ptr_w'(1) : ptr_w'(2));
            end
        end
    end

    //------------------------------------------------------------------
    // Status
    //------------------------------------------------------------------

    assign ocpd_h   = wptr - rptr;
    assign free_h   = ptr_w'(half_n) - ocpd_h;
    assign free_w   = free_h >> 1;
    assign q_empty  = (ocpd_h == '0);
    assign q_one_hw = (ocpd_h == ptr_w'(1));

    // Clamp to the pending counter range
    assign free_words_o = (32'(free_w) > cnt_max) ? txn_cnt_w'(cnt_max)
                                                  : txn_cnt_w'(free_w);

    // Head and the slot behind it
    assign head_idx  = rptr[adr_w-1:0];
    assign next_idx  = head_idx + 1'b1;
    assign data_head = q_data[head_idx];
    assign data_next = q_data[next_idx];
    assign err_head  = q_err[head_idx];
    assign err_next  = q_err[next_idx];
    assign head_rvi  = &data_head[1:0];

    //------------------------------------------------------------------
    // Decoder side
    //------------------------------------------------------------------

    always_comb begin
        idu_vd_o         = 1'b0;
        idu_imem_err_o   = 1'b0;
        idu_err_rvi_hi_o = 1'b0;
        if (!q_empty) begin
            if (q_one_hw) begin
                // Lone upper half of a 32-bit instruction must wait
                idu_vd_o       = ~head_rvi | err_head;
                idu_imem_err_o = err_head;
            end else begin
                idu_vd_o         = 1'b1;
                idu_imem_err_o   = err_head | (head_rvi & err_next);
                idu_err_rvi_hi_o = ~err_head & head_rvi & err_next;
            end
        end
    end

    // Faulted head retires alone
    assign rd_one = ~head_rvi | err_head;
    assign rd_en  = idu_vd_o & idu_rdy_i;

    assign idu_instr_o = head_rvi ? {data_next, data_head} : xlen'(data_head);

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> ((32'(ocpd_h) + (wr_two ? 2 : 1)) <= half_n))
        else $error("instr queue: write overflows occupancy");

endmodule

//--- src/ifu_pkg.sv
//----------------------------------------------------------------------
// Fetch unit shared widths, memory response codes, fetch word union
//----------------------------------------------------------------------

package ifu_pkg;

    // Datapath widths
    localparam int xlen   = 32;
    localparam int half_w = 16;

    //------------------------------------------------------------------
    // Memory response codes
    //------------------------------------------------------------------

    // Idle bus, no response this cycle
    localparam logic [1:0] imem_resp_none = 2'b00;
    // Read data valid
    localparam logic [1:0] imem_resp_ok   = 2'b01;
    // Access fault on this word
    localparam logic [1:0] imem_resp_er   = 2'b10;

    //------------------------------------------------------------------
    // Memory word, seen whole or as two halfwords
    //------------------------------------------------------------------

    typedef union packed {
        logic [xlen-1:0] word;
        struct packed {
            // Upper halfword, address offset 2
            logic [half_w-1:0] hi;
            // Lower halfword, address offset 0
            logic [half_w-1:0] lo;
        } half;
    } fetch_word_u;

endpackage

//--- src/ifu_top.sv
`timescale 1ns/1ps
//----------------------------------------------------------------------
// Instruction fetch unit top level
//----------------------------------------------------------------------

module ifu_top
    import ifu_pkg::*;
#(
    parameter int queue_words = 8,
    parameter int txn_cnt_w   = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    // Instruction memory
    output logic            imem_req_o,
    output logic [xlen-1:0] imem_addr_o,
    input  logic            imem_ack_i,
    input  logic [1:0]      imem_resp_i,
    input  logic [xlen-1:0] imem_rdata_i,
    // Execute stage
    input  logic            pc_new_req_i,
    input  logic [xlen-1:0] pc_new_i,
    input  logic            stop_fetch_i,
    // Decoder
    output logic            idu_vd_o,
    output logic [xlen-1:0] idu_instr_o,
    output logic            idu_imem_err_o,
    output logic            idu_err_rvi_hi_o,
    input  logic            idu_rdy_i
);

    fetch_word_u          rdata_w;
    logic                 resp_ok;
    logic                 resp_er;
    logic                 flush;
    logic [txn_cnt_w-1:0] free_words;
    logic                 wr_full;
    logic                 wr_hi;

    assign rdata_w.word = imem_rdata_i;

    // Request side, response filter
    ifu_fetch_ctrl #(
        .queue_words (queue_words),
        .txn_cnt_w   (txn_cnt_w)
    ) u_fetch_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .stop_fetch_i (stop_fetch_i),
        .pc_new_req_i (pc_new_req_i),
        .pc_new_i     (pc_new_i),
        .imem_ack_i   (imem_ack_i),
        .imem_resp_i  (imem_resp_i),
        .free_words_i (free_words),
        .imem_req_o   (imem_req_o),
        .imem_addr_o  (imem_addr_o),
        .resp_ok_o    (resp_ok),
        .resp_er_o    (resp_er),
        .flush_o      (flush),
        .fetching_o   ()
    );

    ifu_instr_align u_instr_align (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc_new_req_i (pc_new_req_i),
        .pc_new_i     (pc_new_i),
        .imem_rdata_i (rdata_w),
        .resp_ok_i    (resp_ok),
        .wr_full_o    (wr_full),
        .wr_hi_o      (wr_hi)
    );

    ifu_instr_queue #(
        .queue_words (queue_words),
        .txn_cnt_w   (txn_cnt_w)
    ) u_instr_queue (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush_i          (flush),
        .wr_full_i        (wr_full),
        .wr_hi_i          (wr_hi),
        .resp_er_i        (resp_er),
        .rdata_i          (rdata_w),
        .idu_rdy_i        (idu_rdy_i),
        .free_words_o     (free_words),
        .idu_vd_o         (idu_vd_o),
        .idu_instr_o      (idu_instr_o),
        .idu_imem_err_o   (idu_imem_err_o),
        .idu_err_rvi_hi_o (idu_err_rvi_hi_o)
    );

endmodule

//--- verification/tb_ifu_imem.sv
`timescale 1ns/1ps
//----------------------------------------------------------------------
// Instruction memory model, random acknowledge and response latency
//----------------------------------------------------------------------

module tb_ifu_imem (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_i,
    input  logic [31:0] addr_i,
    input  logic [31:0] rom_i [256],
    input  logic [4:0]  err_sel_i,
    output logic        ack_o,
    output logic [1:0]  resp_o,
    output logic [31:0] rdata_o
);

    int unsigned cyc;
    int unsigned last_due;
    int unsigned due;
    logic [31:0] raddr;
    logic [31:0] addr_q [$];
    int unsigned due_q  [$];

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_o    <= 1'b0;
            resp_o   <= 2'b00;
            rdata_o  <= '0;
            cyc      = 0;
            last_due = 0;
            addr_q.delete();
            due_q.delete();
        end else begin
            cyc = cyc + 1;
            resp_o <= 2'b00;
            // Oldest request first, one response per cycle
            if (due_q.size() > 0 && due_q[0] <= cyc) begin
                raddr = addr_q.pop_front();
                void'(due_q.pop_front());
                rdata_o <= rom_i[raddr[9:2]] ^ raddr;
                resp_o  <= (raddr[6:2] == err_sel_i) ? 2'b10 : 2'b01;
            end
            if (req_i && ack_o) begin
                due = cyc + 1 + ($urandom % 4);
                // Keep responses in request order
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                addr_q.push_back(addr_i);
                due_q.push_back(due);
            end
            ack_o <= ($urandom % 4) != 0;
        end
    end

endmodule

//--- verification/tb_ifu_top.sv
`timescale 1ns/1ps
//----------------------------------------------------------------------
// Fetch unit testbench, random PC/stop/ready stimulus, stream model
//----------------------------------------------------------------------

module tb_ifu_top;

    localparam int    seg_n       = 80;
    // Longest segment: PC pulse, run, stop, release
    localparam int    seg_cyc_max = 81;
    localparam longint wd_ns      = longint'(seg_n * seg_cyc_max + 40) * 20 + 1000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic        imem_ack;
    logic [1:0]  imem_resp;
    logic [31:0] imem_rdata;
    logic        pc_new_req;
    logic [31:0] pc_new;
    logic        stop_fetch;
    logic        idu_vd;
    logic [31:0] idu_instr;
    logic        idu_imem_err;
    logic        idu_err_rvi_hi;
    logic        idu_rdy;

    logic [31:0] rom [256];
    logic [4:0]  err_sel;

    // Model state
    logic [31:0] model_pc;
    logic        seg_done;
    logic        halted;
    logic        stopped;
    logic        prev_wait;
    logic [31:0] prev_addr;
    int          err_cnt = 0;
    int          acc_cnt = 0;

    always #5 clk = ~clk;

    ifu_top #(
        .queue_words (8),
        .txn_cnt_w   (4)
    ) u_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .imem_req_o       (imem_req),
        .imem_addr_o      (imem_addr),
        .imem_ack_i       (imem_ack),
        .imem_resp_i      (imem_resp),
        .imem_rdata_i     (imem_rdata),
        .pc_new_req_i     (pc_new_req),
        .pc_new_i         (pc_new),
        .stop_fetch_i     (stop_fetch),
        .idu_vd_o         (idu_vd),
        .idu_instr_o      (idu_instr),
        .idu_imem_err_o   (idu_imem_err),
        .idu_err_rvi_hi_o (idu_err_rvi_hi),
        .idu_rdy_i        (idu_rdy)
    );

    tb_ifu_imem u_imem (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_i     (imem_req),
        .addr_i    (imem_addr),
        .rom_i     (rom),
        .err_sel_i (err_sel),
        .ack_o     (imem_ack),
        .resp_o    (imem_resp),
        .rdata_o   (imem_rdata)
    );

    //------------------------------------------------------------------
    // Reference helpers
    //------------------------------------------------------------------

    function automatic logic [15:0] half_at(input logic [31:0] hpc);
        logic [31:0] wa;
        logic [31:0] w;
        wa = {hpc[31:2], 2'b00};
        w  = rom[wa[9:2]] ^ wa;
        return hpc[1] ? w[31:16] : w[15:0];
    endfunction

    function automatic logic word_err(input logic [31:0] hpc);
        return hpc[6:2] == err_sel;
    endfunction

    task automatic report_fail(input string msg);
        err_cnt = err_cnt + 1;
        $display("FAILED at time %0t: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    // Compare one accepted instruction with the walked stream
    task automatic check_instr();
        logic [15:0] hw0;
        logic [15:0] hw1;
        logic [31:0] exp_instr;
        logic [31:0] instr_pc;
        logic        exp_err;
        logic        exp_hi;
        instr_pc = model_pc;
        hw0 = half_at(model_pc);
        hw1 = half_at(model_pc + 2);
        exp_instr = {16'h0000, hw0};
        exp_err = word_err(model_pc);
        exp_hi = 1'b0;
        if (!exp_err && hw0[1:0] == 2'b11) begin
            exp_instr = {hw1, hw0};
            exp_err = word_err(model_pc + 2);
            exp_hi = exp_err;
            model_pc = model_pc + 4;
        end else begin
            model_pc = model_pc + 2;
        end
        assert (idu_imem_err == exp_err && idu_err_rvi_hi == exp_hi)
        else report_fail($sformatf("err flags %b/%b expected %b/%b",
            idu_imem_err, idu_err_rvi_hi, exp_err, exp_hi));
        // Faulted instruction data is not defined
        if (!exp_err) begin
            assert (idu_instr == exp_instr)
            else report_fail($sformatf("instr %h expected %h at pc %h",
                idu_instr, exp_instr, instr_pc));
        end
        seg_done = exp_err;
    endtask

    //------------------------------------------------------------------
    // Monitor, samples at the rising edge
    //------------------------------------------------------------------

    always @(posedge clk) begin
        if (!rst_n) begin
            stopped   = 1'b1;
            halted    = 1'b0;
            seg_done  = 1'b0;
            prev_wait = 1'b0;
            model_pc  = '0;
        end else begin
            // Stopped or faulted fetch stays quiet until a new PC
            if (stopped) begin
                assert (!idu_vd) else report_fail("decoder valid while stopped");
                assert (!imem_req) else report_fail("memory request while stopped");
            end
            if (halted) begin
                assert (!imem_req) else report_fail("memory request after fetch error");
            end
            if (imem_req) begin
                assert (imem_addr[1:0] == 2'b00)
                else report_fail($sformatf("unaligned request address %h", imem_addr));
            end
            if (prev_wait && imem_req) begin
                assert (imem_addr == prev_addr)
                else report_fail($sformatf("address moved %h -> %h before ack",
                    prev_addr, imem_addr));
            end
            prev_wait = imem_req & ~imem_ack;
            prev_addr = imem_addr;
            if (pc_new_req) begin
                model_pc = pc_new;
                seg_done = 1'b0;
                halted   = 1'b0;
                stopped  = 1'b0;
            end else if (stop_fetch) begin
                stopped = 1'b1;
            end else if (idu_vd && idu_rdy) begin
                acc_cnt = acc_cnt + 1;
                if (seg_done) begin
                    // Trailing halves of the faulted word
                    assert (idu_imem_err)
                    else report_fail("instruction after fetch error without error flag");
                end else begin
                    check_instr();
                end
                if (seg_done) begin
                    halted = 1'b1;
                end
            end
        end
    end

    //------------------------------------------------------------------
    // Stimulus
    //------------------------------------------------------------------

    task automatic run_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            pc_new_req <= 1'b0;
            idu_rdy    <= ($urandom % 4) != 0;
        end
    endtask

    initial begin
        void'($urandom(52));
        for (int i = 0; i < 256; i++) begin
            rom[i] = $urandom;
        end
        err_sel    = 5'($urandom % 32);
        rst_n      = 1'b0;
        pc_new_req = 1'b0;
        pc_new     = '0;
        stop_fetch = 1'b0;
        idu_rdy    = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        for (int s = 0; s < seg_n; s++) begin
            @(posedge clk);
            // Word or halfword aligned start
            pc_new_req <= 1'b1;
            pc_new     <= ($urandom % 4096) & 32'hffff_fffe;
            idu_rdy    <= ($urandom % 4) != 0;
            run_cycles(10 + $urandom % 60);
            if (($urandom % 5) == 0) begin
                stop_fetch <= 1'b1;
                run_cycles(2 + $urandom % 4);
                stop_fetch <= 1'b0;
                run_cycles(3);
            end
        end
        run_cycles(30);
        assert (acc_cnt > 100)
        else report_fail($sformatf("only %0d instructions accepted", acc_cnt));
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(wd_ns);
        $display("Timeout: the run did not finish in the expected time");
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule
